/* sim.f */
soc_pkg.sv
axil_router.sv
pmem_axil.sv
uart_tx_axil.sv
soc_sim_top.sv
tb_clock.sv
soc_asserts.sv
tb_soc.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_soc -f sim.f -o tb_soc_sim &&
./obj_dir/tb_soc_sim +verilator+error+limit+100 | tee /dev/stderr | grep "RESULT: PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tb_soc.sv */
// testbench running directed AXI4-Lite tests on the sim SoC memory, uart and decode errors
module tb_soc;
    import soc_pkg::*;

    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   rst;
    logic                   s_awvalid;
    logic                   s_awready;
    logic [ADDR_WIDTH-1:0]  s_awaddr;
    logic [2:0]             s_awprot;
    logic                   s_wvalid;
    logic                   s_wready;
    logic [DATA_WIDTH-1:0]  s_wdata;
    logic [STRB_WIDTH-1:0]  s_wstrb;
    logic                   s_bvalid;
    logic                   s_bready;
    logic [1:0]             s_bresp;
    logic                   s_arvalid;
    logic                   s_arready;
    logic [ADDR_WIDTH-1:0]  s_araddr;
    logic [2:0]             s_arprot;
    logic                   s_rvalid;
    logic                   s_rready;
    logic [DATA_WIDTH-1:0]  s_rdata;
    logic [1:0]             s_rresp;
    logic                   uart_tx;

    // reference memory image
    axil_word_u     model [PMEM_WORDS];
    bit             written [PMEM_WORDS];
    logic [15:0]    lfsr = 16'd45;
    int             value_errors = 0;
    int             protocol_errors = 0;
    int             cycle = 0;
    int             aw_cycle = 0;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    soc_sim_top i_soc_sim_top (.*);

    bind axil_router soc_asserts i_soc_asserts (.*);

    always_ff @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_value(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAILED t=%0t %s: got %h expected %h", $time, sig, got, exp);
        value_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR t=%0t %s", $time, what);
        protocol_errors++;
    endtask

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hb400 : 16'h0000);
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic axil_word_u merge_word(input axil_word_u old, input logic [31:0] data,
                                              input logic [3:0] strb);
        axil_word_u in_w;
        axil_word_u res;
        in_w.word = data;
        res       = old;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                res.bytes[i] = in_w.bytes[i];
            end
        end
        return res;
    endfunction

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int hold,
                              output logic [1:0] resp);
        int n;
        s_awvalid <= 1'b1;
        s_awaddr  <= addr;
        s_wvalid  <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= strb;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(s_awready && s_wready) && n < TIMEOUT);
        if (!(s_awready && s_wready)) begin
            report_failure($sformatf("write to %h never accepted", addr));
        end
        aw_cycle = cycle;
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_bvalid && n < TIMEOUT);
        if (!s_bvalid) begin
            report_failure($sformatf("no write response for %h", addr));
        end else if (n != 1) begin
            report_value("s_bvalid latency", n, 1);
        end
        // response held off by the manager
        repeat (hold) begin
            @(posedge clk);
            if (!s_bvalid) begin
                report_failure("s_bvalid dropped while s_bready was low");
            end
        end
        s_bready <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_bvalid && n < TIMEOUT);
        resp = s_bresp;
        s_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        int n;
        s_arvalid <= 1'b1;
        s_araddr  <= addr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_arready && n < TIMEOUT);
        if (!s_arready) begin
            report_failure($sformatf("read of %h never accepted", addr));
        end
        s_arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_rvalid && n < TIMEOUT);
        if (!s_rvalid) begin
            report_failure($sformatf("no read response for %h", addr));
        end else if (n != 1) begin
            report_value("s_rvalid latency", n, 1);
        end
        repeat (hold) begin
            @(posedge clk);
            if (!s_rvalid) begin
                report_failure("s_rvalid dropped while s_rready was low");
            end
        end
        s_rready <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_rvalid && n < TIMEOUT);
        data = s_rdata;
        resp = s_rresp;
        s_rready <= 1'b0;
    endtask

    task automatic mem_write(input int idx, input logic [31:0] data, input logic [3:0] strb,
                             input int hold);
        logic [1:0] resp;
        axil_write(PMEM_BASE + idx * 4, data, strb, hold, resp);
        if (resp !== RESP_OKAY) begin
            report_value("s_bresp", 32'(resp), 32'(RESP_OKAY));
        end
        model[idx]   = merge_word(model[idx], data, strb);
        written[idx] = 1'b1;
    endtask

    task automatic mem_read_check(input int idx, input int hold);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(PMEM_BASE + idx * 4, hold, data, resp);
        if (resp !== RESP_OKAY) begin
            report_value("s_rresp", 32'(resp), 32'(RESP_OKAY));
        end
        if (data !== model[idx].word) begin
            report_value($sformatf("s_rdata word %0d", idx), data, model[idx].word);
        end
    endtask

    task automatic verify_memory;
        for (int i = 0; i < PMEM_WORDS; i++) begin
            if (written[i]) begin
                mem_read_check(i, 0);
            end
        end
    endtask

    // 8N1 decode sampled mid-bit
    task automatic uart_expect_byte(input logic [7:0] exp);
        logic [9:0] frame;
        int         n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (uart_tx && n < TIMEOUT);
        if (uart_tx) begin
            report_failure("no uart start bit seen");
        end else begin
            repeat (UART_CLKS_PER_BIT / 2) @(posedge clk);
            frame[0] = uart_tx;
            for (int i = 1; i < UART_FRAME_BITS; i++) begin
                repeat (UART_CLKS_PER_BIT) @(posedge clk);
                frame[i] = uart_tx;
            end
            if (frame[0] !== 1'b0) begin
                report_value("uart_tx start bit", 32'(frame[0]), 0);
            end
            if (frame[8:1] !== exp) begin
                report_value("uart_tx data", 32'(frame[8:1]), 32'(exp));
            end
            if (frame[9] !== 1'b1) begin
                report_value("uart_tx stop bit", 32'(frame[9]), 1);
            end
        end
    endtask

    task automatic test_mem_round_trip;
        mem_write(0, 32'h0123_4567, 4'hf, 0);
        mem_write(1, 32'h89ab_cdef, 4'hf, 0);
        mem_write(64, 32'hcafe_f00d, 4'hf, 0);
        mem_write(255, 32'h5a5a_a5a5, 4'hf, 0);
        verify_memory;
    endtask

    task automatic test_byte_strobes;
        mem_write(16, 32'h1122_3344, 4'hf, 0);
        mem_write(16, 32'haabb_ccdd, 4'b0101, 0);
        mem_write(16, 32'h5566_7788, 4'b1000, 0);
        mem_read_check(16, 0);
    endtask

    task automatic test_uart;
        logic [1:0] resp0;
        logic [1:0] resp1;
        int         first;
        fork
            begin
                axil_write(UART_BASE, 32'h0000_0055, 4'h1, 0, resp0);
                first = aw_cycle;
                axil_write(UART_BASE, 32'h0000_00a3, 4'h1, 0, resp1);
            end
            begin
                uart_expect_byte(8'h55);
                uart_expect_byte(8'ha3);
            end
        join
        if (resp0 !== RESP_OKAY || resp1 !== RESP_OKAY) begin
            report_value("uart s_bresp", 32'({resp0, resp1}), 0);
        end
        // second byte must wait out the whole first frame
        if (aw_cycle - first < UART_FRAME_BITS * UART_CLKS_PER_BIT) begin
            report_failure($sformatf("second uart write accepted %0d cycles after the first",
                                     aw_cycle - first));
        end
    endtask

    task automatic test_decode_errors;
        logic [31:0] data;
        logic [1:0]  resp;
        axil_write(32'h4000_0000, 32'hdead_beef, 4'hf, 0, resp);
        if (resp !== RESP_DECERR) begin
            report_value("s_bresp unmapped", 32'(resp), 32'(RESP_DECERR));
        end
        // just past the memory window where a misroute would alias word 0
        axil_write(PMEM_BASE + PMEM_SIZE, 32'hdead_beef, 4'hf, 0, resp);
        if (resp !== RESP_DECERR) begin
            report_value("s_bresp past memory", 32'(resp), 32'(RESP_DECERR));
        end
        axil_read(32'h0000_1000, 0, data, resp);
        if (resp !== RESP_DECERR) begin
            report_value("s_rresp unmapped", 32'(resp), 32'(RESP_DECERR));
        end
        if (data !== 32'h0) begin
            report_value("s_rdata unmapped", data, 32'h0);
        end
        axil_read(UART_BASE, 0, data, resp);
        if (resp !== RESP_DECERR) begin
            report_value("s_rresp uart", 32'(resp), 32'(RESP_DECERR));
        end
        if (data !== 32'h0) begin
            report_value("s_rdata uart", data, 32'h0);
        end
        verify_memory;
    endtask

    task automatic test_random_traffic;
        int         idx;
        int         hold;
        logic [3:0] strb;
        for (int k = 0; k < 40; k++) begin
            idx  = 32 + int'(take_bits(4));
            hold = int'(take_bits(2));
            if (!written[idx] || take_bits(1) == 32'd1) begin
                strb = written[idx] ? 4'(take_bits(4)) : 4'hf;
                mem_write(idx, take_bits(32), strb, hold);
            end else begin
                mem_read_check(idx, hold);
            end
        end
        verify_memory;
    endtask

    initial begin
        int n;
        int assert_errors;
        s_awvalid <= 1'b0;
        s_awaddr  <= '0;
        s_awprot  <= 3'b000;
        s_wvalid  <= 1'b0;
        s_wdata   <= '0;
        s_wstrb   <= '0;
        s_bready  <= 1'b0;
        s_arvalid <= 1'b0;
        s_araddr  <= '0;
        s_arprot  <= 3'b000;
        s_rready  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst && n < TIMEOUT);
        if (rst) begin
            report_failure("reset never released");
        end
        if (uart_tx !== 1'b1 || s_bvalid !== 1'b0 || s_rvalid !== 1'b0) begin
            report_value("uart_tx/s_bvalid/s_rvalid after reset",
                         32'({uart_tx, s_bvalid, s_rvalid}), 32'h4);
        end
        test_mem_round_trip;
        test_byte_strobes;
        test_uart;
        test_decode_errors;
        test_random_traffic;
        assert_errors = i_soc_sim_top.i_axil_router.i_soc_asserts.fail_count;
        $display("errors: value %0d, protocol %0d, assertion %0d",
                 value_errors, protocol_errors, assert_errors);
        if (value_errors + protocol_errors + assert_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* soc_asserts.sv */
// router protocol checks: held write and read responses, exclusive write locks
module soc_asserts (
    input logic                             clk,
    input logic                             rst,
    input logic                             s_bvalid,
    input logic                             s_bready,
    input logic                             s_rvalid,
    input logic                             s_rready,
    input logic [soc_pkg::DATA_WIDTH-1:0]   s_rdata,
    input logic                             wr_lock_pmem,
    input logic                             wr_lock_uart
);
    int fail_count = 0;

    // write response waits for the manager
    assert property (@(posedge clk) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid)
    else begin
        fail_count++;
        $error("s_bvalid fell before s_bready");
    end

    // read data frozen until taken
    assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else begin
        fail_count++;
        $error("s_rvalid or s_rdata changed before s_rready");
    end

    assert property (@(posedge clk) disable iff (rst)
        !(wr_lock_pmem && wr_lock_uart))
    else begin
        fail_count++;
        $error("memory and uart write locks held together");
    end

endmodule

/* tb_clock.sv */
// testbench clock and reset generator, 100 unit period with reset held for ten cycles
module tb_clock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* soc_sim_top.sv */
// sim SoC top: router feeding the physical memory and the uart transmitter
module soc_sim_top (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            s_awvalid,
    output logic                            s_awready,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  s_awaddr,
    input  logic [2:0]                      s_awprot,
    input  logic                            s_wvalid,
    output logic                            s_wready,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  s_wdata,
    input  logic [soc_pkg::STRB_WIDTH-1:0]  s_wstrb,
    output logic                            s_bvalid,
    input  logic                            s_bready,
    output logic [1:0]                      s_bresp,
    input  logic                            s_arvalid,
    output logic                            s_arready,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  s_araddr,
    input  logic [2:0]                      s_arprot,
    output logic                            s_rvalid,
    input  logic                            s_rready,
    output logic [soc_pkg::DATA_WIDTH-1:0]  s_rdata,
    output logic [1:0]                      s_rresp,

    output logic                            uart_tx
);
    import soc_pkg::*;

    // memory target channels
    logic                   pmem_awvalid;
    logic                   pmem_awready;
    logic [ADDR_WIDTH-1:0]  pmem_awaddr;
    logic                   pmem_wvalid;
    logic                   pmem_wready;
    logic [DATA_WIDTH-1:0]  pmem_wdata;
    logic [STRB_WIDTH-1:0]  pmem_wstrb;
    logic                   pmem_bvalid;
    logic                   pmem_bready;
    logic [1:0]             pmem_bresp;
    logic                   pmem_arvalid;
    logic                   pmem_arready;
    logic [ADDR_WIDTH-1:0]  pmem_araddr;
    logic                   pmem_rvalid;
    logic                   pmem_rready;
    logic [DATA_WIDTH-1:0]  pmem_rdata;
    logic [1:0]             pmem_rresp;

    // uart target channels
    logic                   uart_awvalid;
    logic                   uart_awready;
    logic [ADDR_WIDTH-1:0]  uart_awaddr;
    logic                   uart_wvalid;
    logic                   uart_wready;
    logic [DATA_WIDTH-1:0]  uart_wdata;
    logic [STRB_WIDTH-1:0]  uart_wstrb;
    logic                   uart_bvalid;
    logic                   uart_bready;
    logic [1:0]             uart_bresp;

    // port names match the wires above one to one
    axil_router i_axil_router (.*);

    pmem_axil i_pmem_axil (
        .clk     (clk),
        .rst     (rst),
        .awvalid (pmem_awvalid),
        .awready (pmem_awready),
        .awaddr  (pmem_awaddr),
        .wvalid  (pmem_wvalid),
        .wready  (pmem_wready),
        .wdata   (pmem_wdata),
        .wstrb   (pmem_wstrb),
        .bvalid  (pmem_bvalid),
        .bready  (pmem_bready),
        .bresp   (pmem_bresp),
        .arvalid (pmem_arvalid),
        .arready (pmem_arready),
        .araddr  (pmem_araddr),
        .rvalid  (pmem_rvalid),
        .rready  (pmem_rready),
        .rdata   (pmem_rdata),
        .rresp   (pmem_rresp)
    );

    uart_tx_axil i_uart_tx_axil (
        .clk     (clk),
        .rst     (rst),
        .awvalid (uart_awvalid),
        .awready (uart_awready),
        .awaddr  (uart_awaddr),
        .wvalid  (uart_wvalid),
        .wready  (uart_wready),
        .wdata   (uart_wdata),
        .wstrb   (uart_wstrb),
        .bvalid  (uart_bvalid),
        .bready  (uart_bready),
        .bresp   (uart_bresp),
        .uart_tx (uart_tx)
    );

endmodule

/* uart_tx_axil.sv */
// uart transmitter: write-only AXI4-Lite target sending 8N1 frames on a serial line
module uart_tx_axil (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            awvalid,
    output logic                            awready,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  awaddr,

    input  logic                            wvalid,
    output logic                            wready,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  wdata,
    input  logic [soc_pkg::STRB_WIDTH-1:0]  wstrb,

    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,

    output logic                            uart_tx
);
    import soc_pkg::*;

    logic                                   busy;
    logic [UART_FRAME_BITS-1:0]             shift_reg;
    logic [$clog2(UART_CLKS_PER_BIT)-1:0]   clk_cnt;
    logic [$clog2(UART_FRAME_BITS)-1:0]     bit_cnt;
    logic                                   tx_reg_hit;
    logic                                   bit_done;
    logic                                   frame_start;

    // tx data register at offset 0, offset 4 is a dummy
    assign tx_reg_hit = (awaddr[2:0] == UART_BASE[2:0]);

    // stall the bus while a frame is on the line
    assign awready = awvalid & wvalid & ~bvalid & ~busy;
    assign wready  = awready;
    assign bresp   = RESP_OKAY;

    assign frame_start = awready & tx_reg_hit & wstrb[0];
    assign bit_done    = (int'(clk_cnt) == UART_CLKS_PER_BIT - 1);
    assign uart_tx     = shift_reg[0];

    // response does not wait for the frame
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (awready) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            shift_reg <= '1;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
        end else if (!busy) begin
            if (frame_start) begin
                busy      <= 1'b1;
                // stop, data lsb first, start
                shift_reg <= {1'b1, wdata[7:0], 1'b0};
                clk_cnt   <= '0;
                bit_cnt   <= '0;
            end
        end else if (bit_done) begin
            clk_cnt   <= '0;
            bit_cnt   <= bit_cnt + 1'b1;
            // shift in idle ones behind the frame
            shift_reg <= {1'b1, shift_reg[UART_FRAME_BITS-1:1]};
            if (int'(bit_cnt) == UART_FRAME_BITS - 1) begin
                busy <= 1'b0;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

/* pmem_axil.sv */
// physical memory target: 1 KiB AXI4-Lite RAM with byte strobes and one-cycle responses
module pmem_axil (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            awvalid,
    output logic                            awready,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  awaddr,

    input  logic                            wvalid,
    output logic                            wready,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  wdata,
    input  logic [soc_pkg::STRB_WIDTH-1:0]  wstrb,

    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,

    input  logic                            arvalid,
    output logic                            arready,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  araddr,

    output logic                            rvalid,
    input  logic                            rready,
    output logic [soc_pkg::DATA_WIDTH-1:0]  rdata,
    output logic [1:0]                      rresp
);
    import soc_pkg::*;

    logic [DATA_WIDTH-1:0]          mem [PMEM_WORDS];
    logic [$clog2(PMEM_WORDS)-1:0]  aw_index;
    logic [$clog2(PMEM_WORDS)-1:0]  ar_index;
    axil_word_u                     old_word;
    axil_word_u                     in_word;
    axil_word_u                     new_word;
    logic                           rd_fire;

    // word index, address bits 9:2
    assign aw_index = awaddr[$clog2(PMEM_WORDS)+1:2];
    assign ar_index = araddr[$clog2(PMEM_WORDS)+1:2];

    // AW and W are taken together, one response in flight
    assign awready = awvalid & wvalid & ~bvalid;
    assign wready  = awready;
    assign bresp   = RESP_OKAY;

    assign arready = ~rvalid;
    assign rd_fire = arvalid & arready;
    assign rresp   = RESP_OKAY;

    // merge strobed lanes into the stored word
    always_comb begin
        old_word.word = mem[aw_index];
        in_word.word  = wdata;
        new_word      = old_word;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (wstrb[i]) begin
                new_word.bytes[i] = in_word.bytes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            mem[aw_index] <= new_word.word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (awready) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // read data held until rready
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= mem[ar_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

/* axil_router.sv */
// AXI4-Lite router: decodes addresses, locks targets per direction and merges responses
module axil_router (
    input  logic                            clk,
    input  logic                            rst,

    // manager side
    input  logic                            s_awvalid,
    output logic                            s_awready,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  s_awaddr,
    input  logic [2:0]                      s_awprot,
    input  logic                            s_wvalid,
    output logic                            s_wready,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  s_wdata,
    input  logic [soc_pkg::STRB_WIDTH-1:0]  s_wstrb,
    output logic                            s_bvalid,
    input  logic                            s_bready,
    output logic [1:0]                      s_bresp,
    input  logic                            s_arvalid,
    output logic                            s_arready,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  s_araddr,
    input  logic [2:0]                      s_arprot,
    output logic                            s_rvalid,
    input  logic                            s_rready,
    output logic [soc_pkg::DATA_WIDTH-1:0]  s_rdata,
    output logic [1:0]                      s_rresp,

    // memory target
    output logic                            pmem_awvalid,
    input  logic                            pmem_awready,
    output logic [soc_pkg::ADDR_WIDTH-1:0]  pmem_awaddr,
    output logic                            pmem_wvalid,
    input  logic                            pmem_wready,
    output logic [soc_pkg::DATA_WIDTH-1:0]  pmem_wdata,
    output logic [soc_pkg::STRB_WIDTH-1:0]  pmem_wstrb,
    input  logic                            pmem_bvalid,
    output logic                            pmem_bready,
    input  logic [1:0]                      pmem_bresp,
    output logic                            pmem_arvalid,
    input  logic                            pmem_arready,
    output logic [soc_pkg::ADDR_WIDTH-1:0]  pmem_araddr,
    input  logic                            pmem_rvalid,
    output logic                            pmem_rready,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  pmem_rdata,
    input  logic [1:0]                      pmem_rresp,

    // uart target, write only
    output logic                            uart_awvalid,
    input  logic                            uart_awready,
    output logic [soc_pkg::ADDR_WIDTH-1:0]  uart_awaddr,
    output logic                            uart_wvalid,
    input  logic                            uart_wready,
    output logic [soc_pkg::DATA_WIDTH-1:0]  uart_wdata,
    output logic [soc_pkg::STRB_WIDTH-1:0]  uart_wstrb,
    input  logic                            uart_bvalid,
    output logic                            uart_bready,
    input  logic [1:0]                      uart_bresp
);
    import soc_pkg::*;

    logic aw_pmem_hit;
    logic aw_uart_hit;
    logic ar_pmem_hit;
    logic wr_lock_pmem;
    logic wr_lock_uart;
    logic rd_lock_pmem;
    logic err_bvalid;
    logic err_rvalid;
    logic wr_busy;
    logic rd_busy;

    // s_awprot and s_arprot are carried here but have no effect on routing
    assign aw_pmem_hit = (s_awaddr >= PMEM_BASE) && (s_awaddr < PMEM_BASE + PMEM_SIZE);
    assign aw_uart_hit = (s_awaddr >= UART_BASE) && (s_awaddr < UART_BASE + UART_SIZE);
    // uart has no read side, so only memory claims reads
    assign ar_pmem_hit = (s_araddr >= PMEM_BASE) && (s_araddr < PMEM_BASE + PMEM_SIZE);

    assign wr_busy = wr_lock_pmem | wr_lock_uart | err_bvalid;
    assign rd_busy = rd_lock_pmem | err_rvalid;

    // write request fan-out
    assign pmem_awvalid = s_awvalid & aw_pmem_hit & ~wr_busy;
    assign pmem_wvalid  = s_wvalid & aw_pmem_hit & ~wr_busy;
    assign uart_awvalid = s_awvalid & aw_uart_hit & ~wr_busy;
    assign uart_wvalid  = s_wvalid & aw_uart_hit & ~wr_busy;
    assign pmem_awaddr  = s_awaddr;
    assign pmem_wdata   = s_wdata;
    assign pmem_wstrb   = s_wstrb;
    assign uart_awaddr  = s_awaddr;
    assign uart_wdata   = s_wdata;
    assign uart_wstrb   = s_wstrb;

    // unclaimed writes are taken by the router with AW and W together
    assign s_awready = ~wr_busy & (aw_pmem_hit ? pmem_awready :
                                   aw_uart_hit ? uart_awready : (s_awvalid & s_wvalid));
    assign s_wready  = ~wr_busy & (aw_pmem_hit ? pmem_wready :
                                   aw_uart_hit ? uart_wready : (s_awvalid & s_wvalid));

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_lock_pmem <= 1'b0;
            wr_lock_uart <= 1'b0;
            err_bvalid   <= 1'b0;
        end else if (wr_busy) begin
            if (s_bvalid && s_bready) begin
                wr_lock_pmem <= 1'b0;
                wr_lock_uart <= 1'b0;
                err_bvalid   <= 1'b0;
            end
        end else if (s_awvalid && s_awready) begin
            wr_lock_pmem <= aw_pmem_hit;
            wr_lock_uart <= aw_uart_hit;
            err_bvalid   <= ~aw_pmem_hit & ~aw_uart_hit;
        end
    end

    // write response merge
    assign s_bvalid    = wr_lock_pmem ? pmem_bvalid : wr_lock_uart ? uart_bvalid : err_bvalid;
    assign s_bresp     = wr_lock_pmem ? pmem_bresp : wr_lock_uart ? uart_bresp : RESP_DECERR;
    assign pmem_bready = wr_lock_pmem & s_bready;
    assign uart_bready = wr_lock_uart & s_bready;

    // read request, memory or local decode error
    assign pmem_arvalid = s_arvalid & ar_pmem_hit & ~rd_busy;
    assign pmem_araddr  = s_araddr;
    assign s_arready    = ~rd_busy & (ar_pmem_hit ? pmem_arready : 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_lock_pmem <= 1'b0;
            err_rvalid   <= 1'b0;
        end else if (rd_busy) begin
            if (s_rvalid && s_rready) begin
                rd_lock_pmem <= 1'b0;
                err_rvalid   <= 1'b0;
            end
        end else if (s_arvalid && s_arready) begin
            rd_lock_pmem <= ar_pmem_hit;
            err_rvalid   <= ~ar_pmem_hit;
        end
    end

    assign s_rvalid    = rd_lock_pmem ? pmem_rvalid : err_rvalid;
    assign s_rdata     = rd_lock_pmem ? pmem_rdata : '0;
    assign s_rresp     = rd_lock_pmem ? pmem_rresp : RESP_DECERR;
    assign pmem_rready = rd_lock_pmem & s_rready;

endmodule

/* soc_pkg.sv */
// soc package: address map, bus widths, response codes and UART timing for the sim SoC
package soc_pkg;

    // bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // physical memory window, cut down to 1 KiB for simulation
    localparam logic [ADDR_WIDTH-1:0] PMEM_BASE = 32'h8000_0000;
    localparam logic [ADDR_WIDTH-1:0] PMEM_SIZE = 32'h0000_0400;
    localparam int PMEM_WORDS = 256;

    // uart mmio window, tx data at offset 0
    localparam logic [ADDR_WIDTH-1:0] UART_BASE = 32'ha000_03f8;
    localparam logic [ADDR_WIDTH-1:0] UART_SIZE = 32'h0000_0008;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // 8N1 framing: start, 8 data bits, stop
    localparam int UART_CLKS_PER_BIT = 4;
    localparam int UART_FRAME_BITS   = 10;

    // one data word, whole or by byte lane
    typedef union packed {
        logic [DATA_WIDTH-1:0]      word;
        logic [STRB_WIDTH-1:0][7:0] bytes;
    } axil_word_u;

endpackage
